// ==== files.f ====
source/chip8_pkg.sv
source/key_input.sv
source/opcode_decoder.sv
source/countdown_timer.sv
source/store_sequencer.sv
source/chip8_core.sv
source/chip8_top.sv
verif/chip8_checker.sv
verif/chip8_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module chip8_tb -f files.f -o chip8_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/chip8_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
    echo "failure reported in $LOG"
    exit 1
fi
exit 0

// ==== source/chip8_core.sv ====
`timescale 1ns/1ns

module chip8_core (
    input  logic                            Chip8CLK,
    input  logic                            i_rst_n,
    input  chip8_pkg::op_fields_t           i_fields,
    input  chip8_pkg::key_state_t           i_key,
    input  logic [chip8_pkg::DATA_W-1:0]    i_delay,
    input  logic                            i_store_busy,
    output logic [chip8_pkg::ADDR_W-1:0]    o_pc,
    output logic                            o_delay_load,
    output logic                            o_sound_load,
    output logic [chip8_pkg::DATA_W-1:0]    o_load_value,
    output chip8_pkg::store_req_t           o_store,
    output logic                            o_err
);
    import chip8_pkg::*;

    logic [NUM_REGS-1:0][DATA_W-1:0]    v;
    logic [ADDR_W-1:0]                  stack [STACK_DEPTH];
    logic [$clog2(STACK_DEPTH)-1:0]     sp;
    logic [ADDR_W-1:0]                  pc;
    logic [ADDR_W-1:0]                  index_reg;
    logic                               err;

    logic [DATA_W-1:0]  vx;
    logic [DATA_W-1:0]  vy;
    logic [DATA_W:0]    sum;
    logic [DATA_W:0]    diff_xy;
    logic [DATA_W:0]    diff_yx;
    logic [ADDR_W-1:0]  pc_next;
    logic [ADDR_W-1:0]  pc_skip;
    logic               exec;
    logic               is_misc;
    logic               key_match;
    logic               skip;

    assign vx = v[i_fields.x];
    assign vy = v[i_fields.y];

    // extra bit carries the carry, or the borrow when set
    assign sum     = {1'b0, vx} + {1'b0, vy};
    assign diff_xy = {1'b0, vx} - {1'b0, vy};
    assign diff_yx = {1'b0, vy} - {1'b0, vx};

    assign pc_next = pc + ADDR_W'(INSTR_BYTES);
    assign pc_skip = pc + ADDR_W'(2 * INSTR_BYTES);

    // hold off while a store burst is still going
    assign exec      = !i_store_busy;
    assign is_misc   = (i_fields.cls == OP_MISC);
    assign key_match = i_key.pressed && (DATA_W'(i_key.code) == vx);

    always_comb begin
        case (i_fields.cls)
            OP_SE_IMM:   skip = (vx == i_fields.kk);
            OP_SNE_IMM:  skip = (vx != i_fields.kk);
            OP_SE_REG:   skip = (vx == vy);
            OP_SNE_REG:  skip = (vx != vy);
            OP_KEY_SKIP: skip = (i_fields.kk == 8'h9E) ? key_match : !key_match;
            default:     skip = 1'b0;
        endcase
    end

    // timer loads and store requests leave in the execute cycle
    assign o_delay_load = exec && is_misc && (i_fields.kk == 8'h15);
    assign o_sound_load = exec && is_misc && (i_fields.kk == 8'h18);
    assign o_load_value = vx;

    always_comb begin
        o_store       = '0;
        o_store.valid = exec && is_misc && (i_fields.kk == 8'h33 || i_fields.kk == 8'h55);
        o_store.base  = index_reg;
        if (i_fields.kk == 8'h55) begin
            o_store.kind    = ST_DUMP;
            o_store.count   = i_fields.x;
            o_store.payload = v;
        end else begin
            // BCD needs three bytes, the sequencer splits the digits
            o_store.kind       = ST_BCD;
            o_store.count      = REG_IDX_W'(2);
            o_store.payload[0] = vx;
        end
    end

    // return addresses
    always_ff @(posedge Chip8CLK) begin
        if (exec && i_fields.cls == OP_CALL) begin
            stack[sp] <= pc_next;
        end
    end

    always_ff @(posedge Chip8CLK) begin
        if (!i_rst_n) begin
            pc        <= PC_RESET;
            sp        <= '0;
            index_reg <= '0;
            v         <= '0;
            err       <= 1'b0;
        end else if (exec) begin
            pc <= pc_next;
            case (i_fields.cls)
                OP_SYS: begin
                    pc <= stack[sp - 1'b1];
                    sp <= sp - 1'b1;
                end
                OP_JP:   pc <= i_fields.nnn;
                OP_CALL: begin
                    sp <= sp + 1'b1;
                    pc <= i_fields.nnn;
                end
                OP_SE_IMM, OP_SNE_IMM, OP_SE_REG, OP_SNE_REG, OP_KEY_SKIP: begin
                    if (skip) pc <= pc_skip;
                end
                OP_LD_IMM:  v[i_fields.x] <= i_fields.kk;
                OP_ADD_IMM: v[i_fields.x] <= vx + i_fields.kk;
                OP_ALU: begin
                    // VF written last so it wins when x is F
                    case (i_fields.nibble)
                        4'h0: v[i_fields.x] <= vy;
                        4'h1: v[i_fields.x] <= vx | vy;
                        4'h2: v[i_fields.x] <= vx & vy;
                        4'h3: v[i_fields.x] <= vx ^ vy;
                        4'h4: begin
                            v[i_fields.x] <= sum[DATA_W-1:0];
                            v[VF_INDEX]   <= DATA_W'(sum[DATA_W]);
                        end
                        4'h5: begin
                            v[i_fields.x] <= diff_xy[DATA_W-1:0];
                            v[VF_INDEX]   <= DATA_W'(!diff_xy[DATA_W]);
                        end
                        4'h6: begin
                            v[i_fields.x] <= vy >> 1;
                            v[VF_INDEX]   <= DATA_W'(vy[0]);
                        end
                        4'h7: begin
                            v[i_fields.x] <= diff_yx[DATA_W-1:0];
                            v[VF_INDEX]   <= DATA_W'(!diff_yx[DATA_W]);
                        end
                        4'hE: begin
                            v[i_fields.x] <= vy << 1;
                            v[VF_INDEX]   <= DATA_W'(vy[DATA_W-1]);
                        end
                        default: err <= 1'b1;
                    endcase
                end
                OP_LD_I:  index_reg <= i_fields.nnn;
                OP_JP_V0: pc <= i_fields.nnn + ADDR_W'(v[0]);
                OP_MISC: begin
                    case (i_fields.kk)
                        8'h07: v[i_fields.x] <= i_delay;
                        8'h0A: begin
                            // stay on this opcode until a key shows up
                            if (i_key.pressed) begin
                                v[i_fields.x] <= DATA_W'(i_key.code);
                            end else begin
                                pc <= pc;
                            end
                        end
                        8'h1E: index_reg <= index_reg + ADDR_W'(vx);
                        8'h29: index_reg <= ADDR_W'(vx[KEY_W-1:0] * FONT_STRIDE);
                        8'h55: index_reg <= index_reg + ADDR_W'(i_fields.x) + 1'b1;
                        default: ;
                    endcase
                end
                default: err <= 1'b1;
            endcase
        end
    end

    assign o_pc  = pc;
    assign o_err = err;

endmodule

// ==== source/chip8_pkg.sv ====
package chip8_pkg;

    // machine geometry
    localparam int ADDR_W      = 12;
    localparam int DATA_W      = 8;
    localparam int NUM_REGS    = 16;
    localparam int REG_IDX_W   = $clog2(NUM_REGS);
    localparam int VF_INDEX    = 15;
    localparam int STACK_DEPTH = 16;
    localparam int KEYS        = 16;
    localparam int KEY_W       = $clog2(KEYS);

    // programs are loaded at 0x200
    localparam logic [ADDR_W-1:0] PC_RESET = 12'h200;
    localparam int INSTR_BYTES = 2;
    localparam int FONT_STRIDE = 5;

    // instruction groups after decode
    typedef enum logic [3:0] {
        OP_SYS,
        OP_JP,
        OP_CALL,
        OP_SE_IMM,
        OP_SNE_IMM,
        OP_SE_REG,
        OP_LD_IMM,
        OP_ADD_IMM,
        OP_ALU,
        OP_SNE_REG,
        OP_LD_I,
        OP_JP_V0,
        OP_KEY_SKIP,
        OP_MISC,
        OP_ILLEGAL
    } op_class_e;

    typedef enum logic {
        ST_BCD,
        ST_DUMP
    } store_kind_e;

    typedef struct packed {
        op_class_e             cls;
        logic [REG_IDX_W-1:0]  x;
        logic [REG_IDX_W-1:0]  y;
        logic [3:0]            nibble;
        logic [DATA_W-1:0]     kk;
        logic [ADDR_W-1:0]     nnn;
    } op_fields_t;

    typedef struct packed {
        logic             pressed;
        logic [KEY_W-1:0] code;
    } key_state_t;

    // count holds the index of the last byte, not the byte total
    typedef struct packed {
        logic                             valid;
        store_kind_e                      kind;
        logic [ADDR_W-1:0]                base;
        logic [REG_IDX_W-1:0]             count;
        logic [NUM_REGS-1:0][DATA_W-1:0]  payload;
    } store_req_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } mem_wr_t;

endpackage

// ==== source/chip8_top.sv ====
`timescale 1ns/1ns

module chip8_top (
    input  logic                            Chip8CLK,
    input  logic                            i_rst_n,
    input  logic [15:0]                     i_opcode,
    input  logic [chip8_pkg::KEYS-1:0]      i_keys,
    input  logic                            i_tick,
    output logic [chip8_pkg::ADDR_W-1:0]    o_pc,
    output chip8_pkg::mem_wr_t              o_mem_wr,
    output logic                            o_sound,
    output logic                            o_err
);
    import chip8_pkg::*;

    key_state_t         key;
    op_fields_t         fields;
    store_req_t         store_req;
    logic               store_busy;
    logic               delay_load;
    logic               sound_load;
    logic [DATA_W-1:0]  load_value;
    logic [DATA_W-1:0]  delay_value;
    logic [DATA_W-1:0]  sound_value;

    key_input u_key_input (
        .Chip8CLK (Chip8CLK),
        .i_rst_n  (i_rst_n),
        .i_keys   (i_keys),
        .o_key    (key)
    );

    opcode_decoder u_decoder (
        .i_opcode (i_opcode),
        .o_fields (fields)
    );

    chip8_core u_core (
        .Chip8CLK     (Chip8CLK),
        .i_rst_n      (i_rst_n),
        .i_fields     (fields),
        .i_key        (key),
        .i_delay      (delay_value),
        .i_store_busy (store_busy),
        .o_pc         (o_pc),
        .o_delay_load (delay_load),
        .o_sound_load (sound_load),
        .o_load_value (load_value),
        .o_store      (store_req),
        .o_err        (o_err)
    );

    countdown_timer u_delay_timer (
        .Chip8CLK (Chip8CLK),
        .i_rst_n  (i_rst_n),
        .i_tick   (i_tick),
        .i_load   (delay_load),
        .i_value  (load_value),
        .o_value  (delay_value)
    );

    countdown_timer u_sound_timer (
        .Chip8CLK (Chip8CLK),
        .i_rst_n  (i_rst_n),
        .i_tick   (i_tick),
        .i_load   (sound_load),
        .i_value  (load_value),
        .o_value  (sound_value)
    );

    store_sequencer u_store (
        .Chip8CLK (Chip8CLK),
        .i_rst_n  (i_rst_n),
        .i_req    (store_req),
        .o_busy   (store_busy),
        .o_mem_wr (o_mem_wr)
    );

    // tone plays while the sound timer runs
    assign o_sound = |sound_value;

endmodule

// ==== source/countdown_timer.sv ====
`timescale 1ns/1ns

module countdown_timer (
    input  logic                            Chip8CLK,
    input  logic                            i_rst_n,
    input  logic                            i_tick,
    input  logic                            i_load,
    input  logic [chip8_pkg::DATA_W-1:0]    i_value,
    output logic [chip8_pkg::DATA_W-1:0]    o_value
);
    import chip8_pkg::*;

    logic [DATA_W-1:0] count;

    // a load beats a tick in the same cycle
    always_ff @(posedge Chip8CLK) begin
        if (!i_rst_n) begin
            count <= '0;
        end else if (i_load) begin
            count <= i_value;
        end else if (i_tick && count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign o_value = count;

endmodule

// ==== source/key_input.sv ====
`timescale 1ns/1ns

module key_input (
    input  logic                        Chip8CLK,
    input  logic                        i_rst_n,
    input  logic [chip8_pkg::KEYS-1:0]  i_keys,
    output chip8_pkg::key_state_t       o_key
);
    import chip8_pkg::*;

    logic [KEYS-1:0] sync_1;
    logic [KEYS-1:0] sync_2;

    // two flops, keys come from switches
    always_ff @(posedge Chip8CLK) begin
        if (!i_rst_n) begin
            sync_1 <= '0;
            sync_2 <= '0;
        end else begin
            sync_1 <= i_keys;
            sync_2 <= sync_1;
        end
    end

    // lowest index wins when several keys are held
    always_comb begin
        o_key.pressed = |sync_2;
        o_key.code    = '0;
        for (int k = KEYS - 1; k >= 0; k--) begin
            if (sync_2[k]) begin
                o_key.code = KEY_W'(k);
            end
        end
    end

endmodule

// ==== source/opcode_decoder.sv ====
`timescale 1ns/1ns

module opcode_decoder (
    input  logic [15:0]             i_opcode,
    output chip8_pkg::op_fields_t   o_fields
);
    import chip8_pkg::*;

    logic [3:0] leader;

    assign leader = i_opcode[15:12];

    always_comb begin
        o_fields.x      = i_opcode[11:8];
        o_fields.y      = i_opcode[7:4];
        o_fields.nibble = i_opcode[3:0];
        o_fields.kk     = i_opcode[7:0];
        o_fields.nnn    = i_opcode[11:0];
        o_fields.cls    = OP_ILLEGAL;

        case (leader)
            4'h0: begin
                // only the return is kept, 00E0 has no screen to clear
                if (i_opcode == 16'h00EE) o_fields.cls = OP_SYS;
            end
            4'h1: o_fields.cls = OP_JP;
            4'h2: o_fields.cls = OP_CALL;
            4'h3: o_fields.cls = OP_SE_IMM;
            4'h4: o_fields.cls = OP_SNE_IMM;
            4'h5: begin
                if (i_opcode[3:0] == 4'h0) o_fields.cls = OP_SE_REG;
            end
            4'h6: o_fields.cls = OP_LD_IMM;
            4'h7: o_fields.cls = OP_ADD_IMM;
            4'h8: begin
                if (i_opcode[3] == 1'b0 || i_opcode[3:0] == 4'hE) o_fields.cls = OP_ALU;
            end
            4'h9: begin
                if (i_opcode[3:0] == 4'h0) o_fields.cls = OP_SNE_REG;
            end
            4'hA: o_fields.cls = OP_LD_I;
            4'hB: o_fields.cls = OP_JP_V0;
            4'hE: begin
                if (i_opcode[7:0] == 8'h9E || i_opcode[7:0] == 8'hA1) begin
                    o_fields.cls = OP_KEY_SKIP;
                end
            end
            4'hF: begin
                case (i_opcode[7:0])
                    8'h07, 8'h0A, 8'h15, 8'h18,
                    8'h1E, 8'h29, 8'h33, 8'h55: o_fields.cls = OP_MISC;
                    default: o_fields.cls = OP_ILLEGAL;
                endcase
            end
            // CXNN and DXYN fall through to illegal
            default: o_fields.cls = OP_ILLEGAL;
        endcase
    end

endmodule

// ==== source/store_sequencer.sv ====
`timescale 1ns/1ns

module store_sequencer (
    input  logic                    Chip8CLK,
    input  logic                    i_rst_n,
    input  chip8_pkg::store_req_t   i_req,
    output logic                    o_busy,
    output chip8_pkg::mem_wr_t      o_mem_wr
);
    import chip8_pkg::*;

    logic                               active;
    logic [REG_IDX_W-1:0]               idx;
    logic [REG_IDX_W-1:0]               last;
    logic [ADDR_W-1:0]                  wr_addr;
    logic [NUM_REGS-1:0][DATA_W-1:0]    bytes_q;
    logic [NUM_REGS-1:0][DATA_W-1:0]    bcd;
    logic [DATA_W-1:0]                  value;

    assign value = i_req.payload[0];

    // hundreds, tens, units in the first three slots
    always_comb begin
        bcd    = '0;
        bcd[0] = value / 8'd100;
        bcd[1] = (value % 8'd100) / 8'd10;
        bcd[2] = value % 8'd10;
    end

    always_ff @(posedge Chip8CLK) begin
        if (!i_rst_n) begin
            active <= 1'b0;
            idx    <= '0;
        end else if (i_req.valid) begin
            active <= 1'b1;
            idx    <= '0;
        end else if (active) begin
            if (idx == last) begin
                active <= 1'b0;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

    // burst data and address
    always_ff @(posedge Chip8CLK) begin
        if (i_req.valid) begin
            last    <= i_req.count;
            wr_addr <= i_req.base;
            bytes_q <= (i_req.kind == ST_DUMP) ? i_req.payload : bcd;
        end else if (active) begin
            wr_addr <= wr_addr + 1'b1;
        end
    end

    assign o_busy         = active;
    assign o_mem_wr.valid = active;
    assign o_mem_wr.addr  = wr_addr;
    assign o_mem_wr.data  = bytes_q[idx];

endmodule

// ==== verif/chip8_checker.sv ====
`timescale 1ns/1ns

module chip8_checker (
    input  logic                            Chip8CLK,
    input  logic                            i_rst_n,
    input  logic [chip8_pkg::ADDR_W-1:0]    i_pc,
    input  chip8_pkg::mem_wr_t              i_mem_wr,
    input  logic                            i_sound,
    input  logic                            i_err
);
    import chip8_pkg::*;

    int fail_count = 0;

    // a burst walks up one byte per write
    property burst_addr_step;
        @(posedge Chip8CLK) disable iff (!i_rst_n)
            (i_mem_wr.valid && $past(i_mem_wr.valid))
                |-> (i_mem_wr.addr == $past(i_mem_wr.addr) + 12'd1);
    endproperty

    // only reset clears the error flag
    property err_sticky;
        @(posedge Chip8CLK) $fell(i_err) |-> $past(!i_rst_n);
    endproperty

    property idle_after_reset;
        @(posedge Chip8CLK) $rose(i_rst_n)
            |-> (!i_mem_wr.valid && !i_err && !i_sound && i_pc == PC_RESET);
    endproperty

    assert property (burst_addr_step)
    else begin
        $error("write address did not step by one inside a burst");
        fail_count++;
    end

    assert property (err_sticky)
    else begin
        $error("error flag dropped without a reset");
        fail_count++;
    end

    assert property (idle_after_reset)
    else begin
        $error("outputs not in their reset state after reset");
        fail_count++;
    end

endmodule

bind chip8_top chip8_checker u_chk (
    .Chip8CLK (Chip8CLK),
    .i_rst_n  (i_rst_n),
    .i_pc     (o_pc),
    .i_mem_wr (o_mem_wr),
    .i_sound  (o_sound),
    .i_err    (o_err)
);

// ==== verif/chip8_tb.sv ====
`timescale 1ns/1ns

module chip8_tb;
    import chip8_pkg::*;

    // six programs of a few dozen cycles each plus reset and tick phases, with wide margin
    localparam int MAX_CYCLES = 4000;

    // ALU program body after the three operand loads
    localparam logic [15:0] ALU_OPS [21] = '{
        16'h8200, 16'h8214, 16'h83F0, 16'h8400, 16'h8415, 16'h85F0, 16'h8600,
        16'h8617, 16'h87F0, 16'h8806, 16'h89F0, 16'h8A0E, 16'h8BF0, 16'h8C00,
        16'h8C11, 16'h8D00, 16'h8D12, 16'h8E00, 16'h8E13, 16'hA300, 16'hFF55
    };

    // skips, call and BNNN from 0x200, every wrong path loads EE
    localparam logic [15:0] CTRL_MAIN [16] = '{
        16'h6004, 16'h3004, 16'h61EE, 16'h3006, 16'h6111, 16'h4007, 16'h62EE, 16'h6222,
        16'h6304, 16'h5030, 16'h64EE, 16'h9030, 16'h6444, 16'h2300, 16'h6666, 16'hB31C
    };
    localparam logic [7:0] CTRL_EXPECT [8] = '{
        8'h04, 8'h11, 8'h22, 8'h04, 8'h44, 8'h55, 8'h66, 8'h77
    };

    logic               Chip8CLK;
    logic               i_rst_n;
    logic [15:0]        i_opcode;
    logic [KEYS-1:0]    i_keys;
    logic               i_tick;
    logic [ADDR_W-1:0]  o_pc;
    mem_wr_t            o_mem_wr;
    logic               o_sound;
    logic               o_err;

    logic [DATA_W-1:0]  mem [1 << ADDR_W];
    logic [ADDR_W-1:0]  exp_addr [$];
    logic [DATA_W-1:0]  exp_data [$];
    logic [ADDR_W-1:0]  wp;
    logic [ADDR_W-1:0]  end_addr;
    string              cur_name;
    int                 errors = 0;
    int                 err_mark = 0;
    int                 tests_run = 0;
    int                 tests_failed = 0;
    int                 cycles = 0;

    chip8_top DUT (
        .Chip8CLK (Chip8CLK),
        .i_rst_n  (i_rst_n),
        .i_opcode (i_opcode),
        .i_keys   (i_keys),
        .i_tick   (i_tick),
        .o_pc     (o_pc),
        .o_mem_wr (o_mem_wr),
        .o_sound  (o_sound),
        .o_err    (o_err)
    );

    // program memory answers in the same cycle
    assign i_opcode = {mem[o_pc], mem[o_pc + 12'd1]};

    initial Chip8CLK = 1'b0;
    always #20 Chip8CLK = ~Chip8CLK;

    always @(posedge Chip8CLK) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped after %0d cycles, test %s never finished", cycles, cur_name);
            $display("Some tests failed");
            $finish;
        end
    end

    // every write strobe must match the head of the expected queue
    always @(negedge Chip8CLK) begin
        if (i_rst_n && o_mem_wr.valid) begin
            assert (exp_addr.size() > 0)
            else begin
                $display("test %s wrote %h to %h with no write expected",
                         cur_name, o_mem_wr.data, o_mem_wr.addr);
                errors++;
            end
            if (exp_addr.size() > 0) begin
                assert (o_mem_wr.addr == exp_addr[0] && o_mem_wr.data == exp_data[0])
                else begin
                    $display("mismatch in %s (write): expected %h at %h, actual %h at %h",
                             cur_name, exp_data[0], exp_addr[0], o_mem_wr.data, o_mem_wr.addr);
                    errors++;
                end
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end

    task automatic check_eq(input string what, input logic [15:0] expected,
                            input logic [15:0] actual);
        assert (expected == actual)
        else begin
            $display("mismatch in %s (%s): expected %0h, actual %0h",
                     cur_name, what, expected, actual);
            errors++;
        end
    endtask

    // reset goes low first so the old program cannot run on new memory
    task automatic begin_test(input string name);
        @(posedge Chip8CLK);
        i_rst_n <= 1'b0;
        i_keys  <= '0;
        i_tick  <= 1'b0;
        @(posedge Chip8CLK);
        cur_name = name;
        err_mark = errors;
        exp_addr.delete();
        exp_data.delete();
        for (int a = 0; a < (1 << ADDR_W); a++) begin
            mem[a] = DATA_W'(a ^ (a >> 4));
        end
        wp = PC_RESET;
    endtask

    task automatic set_origin(input logic [ADDR_W-1:0] addr);
        wp = addr;
    endtask

    task automatic emit(input logic [15:0] op);
        mem[wp]         = op[15:8];
        mem[wp + 12'd1] = op[7:0];
        wp = wp + ADDR_W'(INSTR_BYTES);
    endtask

    // self jump marks the end, then reset is released
    task automatic close_program();
        end_addr = wp;
        emit(16'h1000 | 16'(wp));
        repeat (3) @(posedge Chip8CLK);
        i_rst_n <= 1'b1;
    endtask

    task automatic expect_wr(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic run_to(input logic [ADDR_W-1:0] addr);
        @(negedge Chip8CLK);
        while (o_pc != addr) @(negedge Chip8CLK);
    endtask

    // last store burst may still run when the end loop is reached
    task automatic drain_test();
        run_to(end_addr);
        while (o_mem_wr.valid) @(negedge Chip8CLK);
        assert (exp_addr.size() == 0)
        else begin
            $display("test %s ended with %0d expected writes missing", cur_name, exp_addr.size());
            errors++;
        end
    endtask

    task automatic report_test();
        tests_run++;
        if (errors == err_mark) begin
            $display("test %s: ok", cur_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", cur_name, errors - err_mark);
        end
    endtask

    task automatic give_tick();
        @(posedge Chip8CLK);
        i_tick <= 1'b1;
        @(posedge Chip8CLK);
        i_tick <= 1'b0;
        @(negedge Chip8CLK);
    endtask

    function automatic logic [KEY_W-1:0] lowest_key(input logic [KEYS-1:0] keys);
        for (int k = 0; k < KEYS; k++) begin
            if (keys[k]) return KEY_W'(k);
        end
        return '0;
    endfunction

    initial begin
        logic [DATA_W-1:0]  a;
        logic [DATA_W-1:0]  c;
        logic [DATA_W-1:0]  r;
        logic [DATA_W-1:0]  v [NUM_REGS];
        logic [KEYS-1:0]    keys;
        logic [KEY_W-1:0]   key;
        logic [ADDR_W-1:0]  base;
        int                 checks_failed;

        i_rst_n = 1'b0;
        i_keys  = '0;
        i_tick  = 1'b0;
        void'($urandom(65));

        // both operands at 0x80 or above so the add carries
        begin_test("alu");
        a    = DATA_W'($urandom());
        v[0] = DATA_W'($urandom()) | 8'h80;
        v[1] = DATA_W'($urandom()) | 8'h80;
        c    = v[0] - a;
        emit(16'h6000 | 16'(a));
        emit(16'h6100 | 16'(v[1]));
        emit(16'h7000 | 16'(c));
        foreach (ALU_OPS[i]) emit(ALU_OPS[i]);
        v[2]  = v[0] + v[1];
        v[3]  = DATA_W'((9'(v[0]) + 9'(v[1])) >> 8);
        v[4]  = v[0] - v[1];
        v[5]  = DATA_W'(v[0] >= v[1]);
        v[6]  = v[1] - v[0];
        v[7]  = DATA_W'(v[1] >= v[0]);
        v[8]  = v[0] >> 1;
        v[9]  = DATA_W'(v[0][0]);
        v[10] = v[0] << 1;
        v[11] = DATA_W'(v[0][7]);
        v[12] = v[0] | v[1];
        v[13] = v[0] & v[1];
        v[14] = v[0] ^ v[1];
        v[15] = DATA_W'(v[0][7]);
        for (int i = 0; i < NUM_REGS; i++) begin
            expect_wr(12'h300 + ADDR_W'(i), v[i]);
        end
        close_program();
        drain_test();
        report_test();

        begin_test("control");
        foreach (CTRL_MAIN[i]) emit(CTRL_MAIN[i]);
        set_origin(12'h300);
        emit(16'h6555);
        emit(16'h00EE);
        set_origin(12'h320);
        emit(16'h6777);
        emit(16'hA400);
        emit(16'hF755);
        foreach (CTRL_EXPECT[i]) expect_wr(12'h400 + ADDR_W'(i), CTRL_EXPECT[i]);
        close_program();
        drain_test();
        report_test();

        // I reaches 0x310 through FX1E
        begin_test("bcd");
        r = DATA_W'($urandom());
        emit(16'h6000 | 16'(r));
        emit(16'hA300);
        emit(16'h6110);
        emit(16'hF11E);
        emit(16'hF033);
        expect_wr(12'h310, r / 8'd100);
        expect_wr(12'h311, (r / 8'd10) % 8'd10);
        expect_wr(12'h312, r % 8'd10);
        close_program();
        drain_test();
        report_test();

        // several keys held, lowest one at 4 or above
        begin_test("key_wait");
        keys = (KEYS'($urandom()) | 16'h8000) & 16'hFFF0;
        key  = lowest_key(keys);
        base = ADDR_W'(key) * ADDR_W'(FONT_STRIDE);
        emit(16'hF50A);
        emit(16'hF529);
        emit(16'hF555);
        for (int i = 0; i < 5; i++) begin
            expect_wr(base + ADDR_W'(i), '0);
        end
        expect_wr(base + 12'd5, DATA_W'(key));
        close_program();
        run_to(PC_RESET);
        repeat (10) begin
            @(negedge Chip8CLK);
            check_eq("pc during key wait", 16'(PC_RESET), 16'(o_pc));
        end
        @(posedge Chip8CLK);
        i_keys <= keys;
        drain_test();
        report_test();

        // key wait at 0x20A parks the core while ticks are given
        begin_test("timers");
        emit(16'h6003);
        emit(16'hF018);
        emit(16'h6105);
        emit(16'hF115);
        emit(16'hA320);
        emit(16'hF20A);
        emit(16'hF307);
        emit(16'hF355);
        expect_wr(12'h320, 8'd3);
        expect_wr(12'h321, 8'd5);
        expect_wr(12'h322, 8'd4);
        expect_wr(12'h323, 8'd5 - 8'd3);
        close_program();
        run_to(12'h20A);
        check_eq("sound before ticks", 16'd1, 16'(o_sound));
        for (int t = 1; t <= 3; t++) begin
            give_tick();
            check_eq("sound after tick", (t < 3) ? 16'd1 : 16'd0, 16'(o_sound));
        end
        @(posedge Chip8CLK);
        i_keys <= 16'h0010;
        drain_test();
        report_test();

        begin_test("illegal");
        emit(16'h6001);
        emit(16'hD123);
        emit(16'h6002);
        close_program();
        drain_test();
        check_eq("err after illegal opcode", 16'd1, 16'(o_err));
        repeat (5) begin
            @(negedge Chip8CLK);
            check_eq("err held", 16'd1, 16'(o_err));
        end
        @(posedge Chip8CLK);
        i_rst_n <= 1'b0;
        repeat (4) @(posedge Chip8CLK);
        i_rst_n <= 1'b1;
        @(negedge Chip8CLK);
        check_eq("err after reset", 16'd0, 16'(o_err));
        report_test();

        checks_failed = DUT.u_chk.fail_count;
        $display("%0d tests run, %0d failed, %0d errors, %0d checker errors",
                 tests_run, tests_failed, errors, checks_failed);
        if (errors == 0 && checks_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
